// File: hdmi_cfg_pkg.sv
package hdmi_cfg_pkg;

	// ADV7513 main map, with PD pin low
	localparam i2c_pkg::dev_addr_t TX_DEV_ADDR = 7'h39;

	// Entries in the bring-up table
	localparam int INIT_COUNT = 25;

	typedef logic [5:0] cmd_idx_t;

	// Register byte goes out first, then the value
	typedef struct packed {
		i2c_pkg::byte_t reg_addr;
		i2c_pkg::byte_t value;
	} reg_write_t;

	// Bring-up table indexed by position
	function automatic reg_write_t init_entry(input cmd_idx_t idx);
		case (idx)
			6'd0:    init_entry = 16'h4110; // Leave power-down
			6'd1:    init_entry = 16'h9803; // Required fixed values 0x98..0xF9
			6'd2:    init_entry = 16'h9AE0;
			6'd3:    init_entry = 16'h9C30;
			6'd4:    init_entry = 16'h9D01;
			6'd5:    init_entry = 16'hA2A4;
			6'd6:    init_entry = 16'hA3A4;
			6'd7:    init_entry = 16'hE0D0;
			6'd8:    init_entry = 16'hF900;
			6'd9:    init_entry = 16'h1500; // 4:4:4 input and default I2S rate
			6'd10:   init_entry = 16'hBA60; // Clock delay off
			6'd11:   init_entry = 16'h1630; // Input style and color depth
			6'd12:   init_entry = 16'h1700; // Aspect and sync polarity
			6'd13:   init_entry = 16'h1846; // CSC setup
			6'd14:   init_entry = 16'hAF06; // HDMI mode
			6'd15:   init_entry = 16'h0A00; // Audio select and MCLK ratio
			6'd16:   init_entry = 16'h0100; // N value high
			6'd17:   init_entry = 16'h0218; // N value mid
			6'd18:   init_entry = 16'h0380; // N value low
			6'd19:   init_entry = 16'h0B0E;
			6'd20:   init_entry = 16'h0C05; // Audio rate from the stream
			6'd21:   init_entry = 16'h0D10; // I2S word length
			6'd22:   init_entry = 16'h5618; // Picture aspect
			6'd23:   init_entry = 16'h94C0; // HPD and monitor sense interrupt enables
			6'd24:   init_entry = 16'h96C0; // Clear pending interrupts
			default: init_entry = 16'h0000;
		endcase
	endfunction

endpackage

// File: hdmi_init_seq.sv
module hdmi_init_seq (
	input  logic           clk,
	input  logic           reset,
	input  logic           hdmi_int,  // Active low from the transmitter
	input  logic           done,
	input  logic           ack_error,
	output logic           enable,
	output i2c_pkg::byte_t reg_addr,
	output i2c_pkg::byte_t value,
	output logic           ready
);

	typedef enum logic [1:0] {
		ST_ISSUE,
		ST_WAIT_LOW,
		ST_WAIT_HIGH,
		ST_IDLE
	} state_t;

	state_t                   state;
	hdmi_cfg_pkg::cmd_idx_t   idx;
	hdmi_cfg_pkg::reg_write_t entry;
	logic [1:0]               int_sync; // Interrupt pin is asynchronous
	logic                     table_end;
	logic                     issue;

	assign entry     = hdmi_cfg_pkg::init_entry(idx);
	assign table_end = (idx == hdmi_cfg_pkg::cmd_idx_t'(hdmi_cfg_pkg::INIT_COUNT));
	assign issue     = (state == ST_ISSUE) && done && !table_end;

	always_ff @(posedge clk) begin
		if (!reset)
			int_sync <= 2'b11; // Released
		else
			int_sync <= {int_sync[0], hdmi_int};
	end

	always_ff @(posedge clk) begin
		if (!reset) begin
			state  <= ST_ISSUE;
			idx    <= '0;
			enable <= 1'b0;
			ready  <= 1'b0;
		end else begin
			case (state)
				ST_ISSUE: begin
					if (done) begin
						if (table_end) begin
							idx   <= '0;
							ready <= 1'b1; // Whole table written
							state <= ST_IDLE;
						end else begin
							enable <= 1'b1;
							state  <= ST_WAIT_LOW;
						end
					end
				end
				ST_WAIT_LOW: begin
					enable <= 1'b0; // Single-cycle pulse
					if (!done)
						state <= ST_WAIT_HIGH;
				end
				ST_WAIT_HIGH: begin
					if (done) begin
						if (!ack_error)
							idx <= idx + 1'b1; // NACK repeats the same entry
						state <= ST_ISSUE;
					end
				end
				default: begin
					if (!int_sync[1]) begin
						ready <= 1'b0; // Transmitter asks for a rewrite
						state <= ST_ISSUE;
					end
				end
			endcase
		end
	end

	// Entry held steady for the whole write
	always_ff @(posedge clk) begin
		if (issue) begin
			reg_addr <= entry.reg_addr;
			value    <= entry.value;
		end
	end

	a_idx_in_range: assert property (
		@(posedge clk) disable iff (!reset)
		idx <= hdmi_cfg_pkg::cmd_idx_t'(hdmi_cfg_pkg::INIT_COUNT)
	) else $error("hdmi_init_seq index ran past the table");

endmodule

// File: hdmi_tx_config.sv
module hdmi_tx_config #(
	parameter int CLK_HZ = 25_200_000,
	parameter int BUS_HZ = 20_000
) (
	input  logic clk,
	input  logic reset,
	input  logic hdmi_int,
	output logic ready,
	inout  wire  sda,
	inout  wire  scl
);

	// Four quarters per SCL period, never below one clock
	localparam int QUARTER_RAW  = CLK_HZ / (4 * BUS_HZ);
	localparam int QUARTER_CLKS = (QUARTER_RAW > 0) ? QUARTER_RAW : 1;

	logic               seq_enable;
	i2c_pkg::byte_t     seq_reg_addr;
	i2c_pkg::byte_t     seq_value;
	logic               wr_done;
	logic               wr_ack_error;
	logic               m_ena;
	i2c_pkg::dev_addr_t m_addr;
	i2c_pkg::byte_t     m_data_wr;
	logic               m_busy;
	logic               m_ack_error;

	hdmi_init_seq u_seq (
		.clk       (clk),
		.reset     (reset),
		.hdmi_int  (hdmi_int),
		.done      (wr_done),
		.ack_error (wr_ack_error),
		.enable    (seq_enable),
		.reg_addr  (seq_reg_addr),
		.value     (seq_value),
		.ready     (ready)
	);

	i2c_reg_writer u_writer (
		.clk              (clk),
		.reset            (reset),
		.reg_addr         (seq_reg_addr),
		.value            (seq_value),
		.enable           (seq_enable),
		.busy             (m_busy),
		.master_ack_error (m_ack_error),
		.done             (wr_done),
		.ack_error        (wr_ack_error),
		.ena              (m_ena),
		.addr             (m_addr),
		.data_wr          (m_data_wr)
	);

	i2c_bit_master #(
		.QUARTER_CLKS (QUARTER_CLKS)
	) u_master (
		.clk       (clk),
		.reset     (reset),
		.ena       (m_ena),
		.addr      (m_addr),
		.data_wr   (m_data_wr),
		.busy      (m_busy),
		.ack_error (m_ack_error),
		.sda       (sda),
		.scl       (scl)
	);

endmodule

// File: i2c_bit_master.sv
module i2c_bit_master #(
	parameter int QUARTER_CLKS = 4
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               ena,       // Keep high to chain another byte
	input  i2c_pkg::dev_addr_t addr,
	input  i2c_pkg::byte_t     data_wr,
	output logic               busy,
	output logic               ack_error, // Sticky for the whole transaction
	inout  wire                sda,
	inout  wire                scl
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_START,
		ST_ADDR,
		ST_ACK_ADDR,
		ST_DATA,
		ST_ACK_DATA,
		ST_STOP
	} state_t;

	state_t                state;
	i2c_pkg::quarter_cnt_t qcnt;      // Clocks within a quarter
	logic [1:0]            phase;     // Quarter within the bit
	logic [2:0]            bit_cnt;
	i2c_pkg::byte_t        shreg;     // Outgoing byte, MSB first
	i2c_pkg::byte_t        data_hold; // First data byte waits here during address
	logic                  load_next; // Busy dip cycle before a chained byte
	logic                  scl_low;
	logic                  sda_low;
	logic                  tick;
	logic                  bit_out;
	logic                  in_ack;

	assign tick    = (qcnt == i2c_pkg::quarter_cnt_t'(QUARTER_CLKS - 1));
	assign bit_out = load_next ? data_wr[7] : shreg[7]; // Covers a one-clock quarter
	assign in_ack  = (state == ST_ACK_ADDR) || (state == ST_ACK_DATA);

	// Open drain, pull-ups on the board
	assign scl = scl_low ? 1'b0 : 1'bz;
	assign sda = sda_low ? 1'b0 : 1'bz;

	always_ff @(posedge clk) begin
		if (!reset) begin
			state     <= ST_IDLE;
			qcnt      <= '0;
			phase     <= '0;
			bit_cnt   <= '0;
			busy      <= 1'b0;
			ack_error <= 1'b0;
			load_next <= 1'b0;
			scl_low   <= 1'b0;
			sda_low   <= 1'b0;
		end else begin
			if (load_next) begin
				shreg     <= data_wr; // Latched with the busy rise
				busy      <= 1'b1;
				load_next <= 1'b0;
			end
			if (state == ST_IDLE) begin
				qcnt  <= '0;
				phase <= '0;
				if (ena) begin
					shreg     <= i2c_pkg::addr_byte(addr, i2c_pkg::RW_WRITE);
					data_hold <= data_wr;
					busy      <= 1'b1;
					ack_error <= 1'b0; // New transaction
					state     <= ST_START;
				end
			end else if (!tick) begin
				qcnt <= qcnt + 1'b1;
			end else begin
				qcnt  <= '0;
				phase <= phase + 1'b1;
				case (phase)
					2'd0: begin
						// SCL already low so SDA may change
						case (state)
							ST_ADDR, ST_DATA:         sda_low <= !bit_out;
							ST_ACK_ADDR, ST_ACK_DATA: sda_low <= 1'b0; // Slave owns SDA
							ST_STOP:                  sda_low <= 1'b1;
							default:                  sda_low <= sda_low;
						endcase
					end
					2'd1: begin
						scl_low <= 1'b0; // SCL high for the rest of the bit
						if (state == ST_START)
							sda_low <= 1'b1; // Start condition
					end
					2'd2: begin
						if (in_ack && (sda != i2c_pkg::SDA_ACK))
							ack_error <= 1'b1; // Keep going, stop comes anyway
						if (state == ST_STOP)
							sda_low <= 1'b0; // Stop condition
					end
					default: begin
						scl_low <= (state != ST_STOP);
						case (state)
							ST_START: begin
								bit_cnt <= i2c_pkg::BYTE_MSB;
								state   <= ST_ADDR;
							end
							ST_ADDR, ST_DATA: begin
								shreg   <= shreg << 1;
								bit_cnt <= bit_cnt - 1'b1;
								if (bit_cnt == 3'd0)
									state <= (state == ST_ADDR) ? ST_ACK_ADDR : ST_ACK_DATA;
							end
							ST_ACK_ADDR: begin
								shreg   <= data_hold;
								bit_cnt <= i2c_pkg::BYTE_MSB;
								state   <= ST_DATA;
							end
							ST_ACK_DATA: begin
								bit_cnt <= i2c_pkg::BYTE_MSB;
								if (ena) begin
									busy      <= 1'b0; // Next cycle rises with the latch
									load_next <= 1'b1;
									state     <= ST_DATA;
								end else begin
									state <= ST_STOP;
								end
							end
							ST_STOP: begin
								busy  <= 1'b0; // Bus free again
								state <= ST_IDLE;
							end
							default: state <= ST_IDLE;
						endcase
					end
				endcase
			end
		end
	end

	// Bus must stay released between transactions
	a_idle_scl_released: assert property (
		@(posedge clk) disable iff (!reset) (state == ST_IDLE) |-> !scl_low
	) else $error("i2c_bit_master drives scl low while idle");

endmodule

// File: i2c_pkg.sv
package i2c_pkg;

	// Clocks per quarter of an SCL period
	typedef logic [15:0] quarter_cnt_t;

	// 7-bit slave address as sent on the bus
	typedef logic [6:0] dev_addr_t;

	// One byte on the wire
	typedef logic [7:0] byte_t;

	// R/W bit appended to the device address
	localparam logic RW_WRITE = 1'b0;
	localparam logic RW_READ  = 1'b1; // Not issued by the master

	// Level of SDA in the ninth bit
	localparam logic SDA_ACK  = 1'b0;
	localparam logic SDA_NACK = 1'b1;

	// Bit counter start for a byte, MSB first
	localparam logic [2:0] BYTE_MSB = 3'd7;

	// Bit periods per byte including the acknowledge slot
	localparam int BITS_PER_SLOT = 9;

	// Address byte as it appears on the bus
	function automatic byte_t addr_byte(input dev_addr_t addr, input logic rw);
		return {addr, rw};
	endfunction

endpackage

// File: i2c_reg_writer.sv
module i2c_reg_writer (
	input  logic               clk,
	input  logic               reset,
	input  i2c_pkg::byte_t     reg_addr,
	input  i2c_pkg::byte_t     value,
	input  logic               enable,           // One-cycle request
	input  logic               busy,
	input  logic               master_ack_error,
	output logic               done,             // High while idle
	output logic               ack_error,        // Valid once done is back
	output logic               ena,
	output i2c_pkg::dev_addr_t addr,
	output i2c_pkg::byte_t     data_wr
);

	logic           busy_d;
	logic [1:0]     rise_cnt;   // Bytes taken by the master after the address
	i2c_pkg::byte_t value_hold;
	logic           start;
	logic           busy_rise;
	logic           busy_fall;

	// Only one device on this bus
	assign addr = hdmi_cfg_pkg::TX_DEV_ADDR;

	assign start     = enable && done;
	assign busy_rise = busy && !busy_d;
	assign busy_fall = !busy && busy_d;

	always_ff @(posedge clk) begin
		if (!reset) begin
			busy_d    <= 1'b0;
			rise_cnt  <= '0;
			done      <= 1'b1;
			ack_error <= 1'b0;
			ena       <= 1'b0;
		end else begin
			busy_d <= busy;
			if (start) begin
				done      <= 1'b0;
				ena       <= 1'b1;
				rise_cnt  <= '0;
				ack_error <= 1'b0;
			end else if (busy_rise) begin
				rise_cnt <= rise_cnt + 1'b1;
				if (rise_cnt == 2'd1)
					ena <= 1'b0; // Value byte latched, stop after it
			end else if (busy_fall && (rise_cnt == 2'd2)) begin
				done      <= 1'b1; // Stop has completed
				ack_error <= master_ack_error;
			end
		end
	end

	// Byte fed to the master
	always_ff @(posedge clk) begin
		if (start) begin
			data_wr    <= reg_addr; // Taken with the address on the first rise
			value_hold <= value;
		end else if (busy_rise && (rise_cnt == 2'd0)) begin
			data_wr <= value_hold;
		end
	end

	// Sequencer must wait for the previous write
	a_enable_only_when_done: assert property (
		@(posedge clk) disable iff (!reset) enable |-> done
	) else $error("i2c_reg_writer got enable while a write is in flight");

endmodule

// File: project.f
i2c_pkg.sv
hdmi_cfg_pkg.sv
i2c_bit_master.sv
i2c_reg_writer.sv
hdmi_init_seq.sv
hdmi_tx_config.sv
tb_i2c_slave.sv
tb_hdmi_tx_config.sv

// File: tb_hdmi_tx_config.sv
module tb_hdmi_tx_config;

	localparam int READY_TIMEOUT = 20000; // Well above 26 writes at 16 clocks per bit
	localparam int HOLD_CYCLES   = 300;

	logic clk = 1'b0;
	logic reset;
	logic hdmi_int;
	logic ready;
	int   nack_index;
	int   count;
	int   errors = 0;
	int   nack_pick;
	int   base;
	wire  sda;
	wire  scl;

	pullup (sda);
	pullup (scl);

	// 100 MHz over 4 x 6.25 MHz gives 4 clocks per quarter
	hdmi_tx_config #(
		.CLK_HZ (100_000_000),
		.BUS_HZ (6_250_000)
	) dut (
		.clk      (clk),
		.reset    (reset),
		.hdmi_int (hdmi_int),
		.ready    (ready),
		.sda      (sda),
		.scl      (scl)
	);

	tb_i2c_slave slave (
		.nack_index (nack_index),
		.count      (count),
		.sda        (sda),
		.scl        (scl)
	);

	always #5 clk = ~clk;

	task automatic check_byte(input string name, input i2c_pkg::byte_t exp,
			input i2c_pkg::byte_t act);
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_addr(input string name, input i2c_pkg::dev_addr_t exp,
			input i2c_pkg::dev_addr_t act);
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %0t %s expected %b got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			errors++;
			$display("[ERROR] %0t %s expected %0d got %0d", $time, name, exp, act);
		end
	endtask

	// Logged transaction against one table entry
	task automatic check_record(input int rec, input int idx);
		hdmi_cfg_pkg::reg_write_t entry;
		entry = hdmi_cfg_pkg::init_entry(hdmi_cfg_pkg::cmd_idx_t'(idx));
		check_addr($sformatf("addr_log[%0d]", rec), hdmi_cfg_pkg::TX_DEV_ADDR,
			slave.addr_log[rec][7:1]);
		check_bit($sformatf("rw[%0d]", rec), i2c_pkg::RW_WRITE, slave.addr_log[rec][0]);
		check_byte($sformatf("reg_log[%0d]", rec), entry.reg_addr, slave.reg_log[rec]);
		check_byte($sformatf("val_log[%0d]", rec), entry.value, slave.val_log[rec]);
	endtask

	task automatic wait_ready(input logic level, input int limit);
		int cycles;
		cycles = 0;
		while (ready !== level && cycles < limit) begin
			@(posedge clk);
			cycles++;
		end
		if (ready !== level) begin
			errors++;
			$display("Timeout: ready did not go to %0b within %0d cycles", level, limit);
		end
	endtask

	// Ready must sit still while the interrupt line is idle
	task automatic hold_ready(input int expected_count);
		int n;
		n = 0;
		while (n < HOLD_CYCLES && ready === 1'b1) begin
			@(posedge clk);
			n++;
		end
		check_bit("ready", 1'b1, ready);
		check_count("count", expected_count, count); // No extra writes
	endtask

	task automatic pulse_int();
		@(posedge clk);
		hdmi_int <= 1'b0;
		repeat (4) @(posedge clk); // Longer than the synchronizer
		hdmi_int <= 1'b1;
		wait_ready(1'b0, 20);
	endtask

	task automatic full_bringup();
		wait_ready(1'b1, READY_TIMEOUT);
		check_count("count", hdmi_cfg_pkg::INIT_COUNT, count); // All stops seen first
		for (int i = 0; i < hdmi_cfg_pkg::INIT_COUNT; i++)
			check_record(i, i);
		hold_ready(hdmi_cfg_pkg::INIT_COUNT);
	endtask

	task automatic rewrite_on_interrupt();
		base = count;
		pulse_int();
		wait_ready(1'b1, READY_TIMEOUT);
		check_count("count", base + hdmi_cfg_pkg::INIT_COUNT, count);
		for (int i = 0; i < hdmi_cfg_pkg::INIT_COUNT; i++)
			check_record(base + i, i);
		hold_ready(base + hdmi_cfg_pkg::INIT_COUNT);
	endtask

	// Refused entry shows up twice in a row
	task automatic retry_after_nack();
		base      = count;
		nack_pick = $urandom % hdmi_cfg_pkg::INIT_COUNT;
		nack_index <= base + nack_pick;
		pulse_int();
		wait_ready(1'b1, READY_TIMEOUT);
		check_count("count", base + hdmi_cfg_pkg::INIT_COUNT + 1, count);
		for (int i = 0; i <= hdmi_cfg_pkg::INIT_COUNT; i++)
			check_record(base + i, (i <= nack_pick) ? i : i - 1);
		nack_index <= -1;
		hold_ready(base + hdmi_cfg_pkg::INIT_COUNT + 1);
	endtask

	initial begin
		reset      = 1'b0;
		hdmi_int   = 1'b1;
		nack_index = -1;
		nack_pick  = $urandom(32'h2e72_b5fd);
		repeat (2) @(posedge clk);
		check_bit("ready", 1'b0, ready);
		check_bit("sda", 1'b1, sda); // Bus released by both sides
		check_bit("scl", 1'b1, scl);
		reset <= 1'b1;
		full_bringup();
		rewrite_on_interrupt();
		retry_after_nack();
		$display("Errors: %0d", errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// File: tb_i2c_slave.sv
module tb_i2c_slave (
	input  int  nack_index, // Transaction to refuse, -1 for none
	output int  count,      // Transactions closed by a stop
	inout  wire sda,
	input  wire scl
);

	// One entry per transaction, in bus order
	i2c_pkg::byte_t addr_log [0:255];
	i2c_pkg::byte_t reg_log  [0:255];
	i2c_pkg::byte_t val_log  [0:255];

	i2c_pkg::byte_t shreg;
	i2c_pkg::byte_t bytes [0:2]; // Address, register, value
	int             bit_cnt;     // 8 means ack slot pending, 9 means ack clock high
	int             byte_cnt;
	logic           active;
	logic           sda_low;

	assign sda = sda_low ? 1'b0 : 1'bz;

	initial begin
		count    = 0;
		bit_cnt  = 0;
		byte_cnt = 0;
		active   = 1'b0;
		sda_low  = 1'b0;
	end

	// Start condition
	always @(negedge sda) begin
		if (scl === 1'b1) begin
			active   = 1'b1;
			bit_cnt  = 0;
			byte_cnt = 0;
			sda_low  = 1'b0;
		end
	end

	// Stop condition closes the record
	always @(posedge sda) begin
		if (scl === 1'b1 && active) begin
			active = 1'b0;
			if (byte_cnt == 3 && count < 256) begin
				addr_log[count] = bytes[0];
				reg_log[count]  = bytes[1];
				val_log[count]  = bytes[2];
				count           = count + 1;
			end
		end
	end

	// Data valid while SCL is high
	always @(posedge scl) begin
		if (active) begin
			if (bit_cnt < 8) begin
				shreg   = {shreg[6:0], sda}; // MSB first
				bit_cnt = bit_cnt + 1;
			end else begin
				bit_cnt = 9;
			end
		end
	end

	// SDA may only change while SCL is low
	always @(negedge scl) begin
		if (active) begin
			if (bit_cnt == 8) begin
				if (byte_cnt < 3)
					bytes[byte_cnt] = shreg;
				// Refuse the value byte of the chosen transaction
				sda_low = !((count == nack_index) && (byte_cnt == 2));
			end else if (bit_cnt == 9) begin
				sda_low  = 1'b0; // Hand SDA back to the master
				bit_cnt  = 0;
				byte_cnt = byte_cnt + 1;
			end
		end
	end

endmodule
